// File: rtl/umi_pkg.sv
/* UMI command set
   command encodings, packet field types and atomic opcodes */
`default_nettype none

package umi_pkg;

   localparam int umi_cmd_w  = 8;   // command field width
   localparam int umi_data_w = 32;  // single word payload

   // bit 0 = response, [3:0] = class, [7:4] = atomic opcode
   typedef logic [umi_cmd_w-1:0]  umi_cmd_t;
   typedef logic [umi_data_w-1:0] umi_data_t;

   // request commands
   localparam umi_cmd_t umi_invalid       = 8'h00;
   localparam umi_cmd_t umi_req_read      = 8'h02;
   localparam umi_cmd_t umi_req_posted    = 8'h04;
   localparam umi_cmd_t umi_req_write_ack = 8'h06;
   localparam umi_cmd_t umi_req_atomic    = 8'h08;  // class nibble, opcode above

   // full atomic commands, opcode in high nibble
   localparam umi_cmd_t umi_req_atomic_add  = 8'h08;
   localparam umi_cmd_t umi_req_atomic_and  = 8'h18;
   localparam umi_cmd_t umi_req_atomic_or   = 8'h28;
   localparam umi_cmd_t umi_req_atomic_xor  = 8'h38;
   localparam umi_cmd_t umi_req_atomic_max  = 8'h48;
   localparam umi_cmd_t umi_req_atomic_min  = 8'h58;
   localparam umi_cmd_t umi_req_atomic_maxu = 8'h68;
   localparam umi_cmd_t umi_req_atomic_minu = 8'h78;
   localparam umi_cmd_t umi_req_atomic_swap = 8'h88;

   // response commands
   localparam umi_cmd_t umi_resp_read  = 8'h03;  // read data / atomic old word
   localparam umi_cmd_t umi_resp_write = 8'h07;  // write ack, no data
   localparam umi_cmd_t umi_resp_err   = 8'h0F;  // anything not handled

   // atomic opcodes, value = high nibble of command
   typedef enum logic [3:0] {
      umi_atomic_add  = 4'd0,
      umi_atomic_and  = 4'd1,
      umi_atomic_or   = 4'd2,
      umi_atomic_xor  = 4'd3,
      umi_atomic_max  = 4'd4,  // signed
      umi_atomic_min  = 4'd5,  // signed
      umi_atomic_maxu = 4'd6,
      umi_atomic_minu = 4'd7,
      umi_atomic_swap = 4'd8
   } umi_atomic_op_t;

endpackage

`default_nettype wire

// File: rtl/mem_pkg.sv
/* shared memory definitions
   word array size, address type and arbiter client count */
`default_nettype none

package mem_pkg;

   localparam int mem_depth  = 256;              // words
   localparam int mem_addr_w = $clog2(mem_depth);
   localparam int mem_ports  = 2;                // arbiter clients, port a and b

   // word address, one UMI word per entry
   typedef logic [mem_addr_w-1:0] mem_addr_t;

   // storage word, same width as a UMI data word
   typedef umi_pkg::umi_data_t mem_data_t;

endpackage

`default_nettype wire

// File: rtl/umi_decode.sv
/* UMI command decoder
   combinational class flags and atomic opcode from one command byte */
`timescale 1ns/1ns
`default_nettype none

module umi_decode (
   input  umi_pkg::umi_cmd_t       command,
   output logic                    cmd_invalid,      // all zero command
   output logic                    cmd_request,
   output logic                    cmd_response,
   output logic                    cmd_read,
   output logic                    cmd_write_posted,
   output logic                    cmd_write_ack,
   output logic                    cmd_atomic,       // any read-modify-write
   output umi_pkg::umi_atomic_op_t cmd_atomic_op,
   output logic                    cmd_supported     // endpoint can serve it
);

   import umi_pkg::*;

   logic op_in_range;  // opcode 0..8 only

   assign cmd_invalid  = (command == umi_invalid);

   // direction from bit 0
   assign cmd_request  = ~command[0] & ~cmd_invalid;
   assign cmd_response =  command[0] & ~cmd_invalid;

   // plain classes need the whole byte, no flavours here
   assign cmd_read         = (command == umi_req_read);
   assign cmd_write_posted = (command == umi_req_posted);
   assign cmd_write_ack    = (command == umi_req_write_ack);

   // atomic class by low nibble, opcode above
   assign cmd_atomic    = (command[3:0] == umi_req_atomic[3:0]);
   assign cmd_atomic_op = umi_atomic_op_t'(command[7:4]);
   assign op_in_range   = (command[7:4] <= 4'd8);

   // responses and unknown classes fall out here
   assign cmd_supported = cmd_read
                        | cmd_write_posted
                        | cmd_write_ack
                        | (cmd_atomic & op_in_range);

endmodule

`default_nettype wire

// File: rtl/umi_atomic_alu.sv
/* atomic ALU
   new memory word from the old word and the request operand */
`timescale 1ns/1ns
`default_nettype none

module umi_atomic_alu (
   input  umi_pkg::umi_atomic_op_t op,
   input  umi_pkg::umi_data_t      old_data,  // word read from memory
   input  umi_pkg::umi_data_t      operand,   // request data
   output umi_pkg::umi_data_t      new_data   // word to write back
);

   import umi_pkg::*;

   logic gt_s;  // old > operand, signed
   logic gt_u;  // old > operand, unsigned

   assign gt_s = ($signed(old_data) > $signed(operand));
   assign gt_u = (old_data > operand);

   always_comb begin
      case (op)
         umi_atomic_add:  new_data = old_data + operand;  // wraps
         umi_atomic_and:  new_data = old_data & operand;
         umi_atomic_or:   new_data = old_data | operand;
         umi_atomic_xor:  new_data = old_data ^ operand;
         umi_atomic_max:  new_data = gt_s ? old_data : operand;
         umi_atomic_min:  new_data = gt_s ? operand : old_data;
         umi_atomic_maxu: new_data = gt_u ? old_data : operand;
         umi_atomic_minu: new_data = gt_u ? operand : old_data;
         umi_atomic_swap: new_data = operand;  // old word goes back in response
         // opcodes 9..15 never get here, keep memory as is
         default:         new_data = old_data;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/umi_endpoint.sv
/* UMI memory endpoint
   one request in flight, memory access via arbiter, single response */
`timescale 1ns/1ns
`default_nettype none

module umi_endpoint (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   output logic               req_ready,
   input  umi_pkg::umi_cmd_t  req_cmd,
   input  mem_pkg::mem_addr_t req_addr,
   input  umi_pkg::umi_data_t req_data,
   output logic               resp_valid,
   input  logic               resp_ready,
   output umi_pkg::umi_cmd_t  resp_cmd,
   output umi_pkg::umi_data_t resp_data,
   output logic               mem_req,
   input  logic               mem_gnt,    // access happens on this edge
   output logic               mem_we,
   output mem_pkg::mem_addr_t mem_addr,
   output umi_pkg::umi_data_t mem_wdata,
   input  umi_pkg::umi_data_t mem_rdata   // one cycle after granted read
);

   import umi_pkg::*;
   import mem_pkg::*;

   typedef enum logic [2:0] {
      st_idle, st_mem_read, st_read_wait, st_mem_write, st_respond
   } ep_state_t;

   ep_state_t state_q, state_d;

   umi_cmd_t       cmd_q;    // held command
   mem_addr_t      addr_q;
   umi_data_t      data_q;   // write data, operand, then atomic result
   umi_cmd_t       dec_cmd;
   logic           is_read, is_posted, is_ack, is_atomic, is_supported;
   umi_atomic_op_t atomic_op;
   umi_data_t      alu_result;
   logic           accept;

   // decode live command while idle, held one afterwards
   assign dec_cmd = (state_q == st_idle) ? req_cmd : cmd_q;

   umi_decode u_decode (
      .command          (dec_cmd),
      .cmd_invalid      (),
      .cmd_request      (),
      .cmd_response     (),
      .cmd_read         (is_read),
      .cmd_write_posted (is_posted),
      .cmd_write_ack    (is_ack),
      .cmd_atomic       (is_atomic),
      .cmd_atomic_op    (atomic_op),
      .cmd_supported    (is_supported)
   );

   umi_atomic_alu u_alu (
      .op       (atomic_op),
      .old_data (mem_rdata),
      .operand  (data_q),
      .new_data (alu_result)
   );

   assign req_ready  = (state_q == st_idle);
   assign accept     = req_valid & req_ready;
   assign resp_valid = (state_q == st_respond);

   // memory side, request held until granted
   assign mem_req   = (state_q == st_mem_read) | (state_q == st_mem_write);
   assign mem_we    = (state_q == st_mem_write);
   assign mem_addr  = addr_q;
   assign mem_wdata = data_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: if (req_valid) begin
            if (!is_supported)            state_d = st_respond;  // error, no access
            else if (is_read | is_atomic) state_d = st_mem_read;
            else                          state_d = st_mem_write;
         end
         st_mem_read:  if (mem_gnt) state_d = st_read_wait;
         st_read_wait: state_d = is_atomic ? st_mem_write : st_respond;
         st_mem_write: if (mem_gnt) state_d = is_posted ? st_idle : st_respond;
         st_respond:   if (resp_ready) state_d = st_idle;  // hold under back-pressure
         default:      state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) state_q <= st_idle;
      else        state_q <= state_d;
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (accept) begin
         cmd_q     <= req_cmd;
         addr_q    <= req_addr;
         data_q    <= req_data;
         resp_data <= '0;  // ack and error carry zero
         if (!is_supported)            resp_cmd <= umi_resp_err;
         else if (is_read | is_atomic) resp_cmd <= umi_resp_read;
         else if (is_ack)              resp_cmd <= umi_resp_write;
         else                          resp_cmd <= umi_invalid;  // posted, never sent
      end
      if (state_q == st_read_wait) begin
         resp_data <= mem_rdata;   // old word for atomics too
         data_q    <= alu_result;  // write-back value, only used by atomics
      end
   end

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
/* round-robin memory arbiter
   two endpoint requests onto one SRAM port, combinational grant */
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_a,
   input  logic               req_b,
   output logic               gnt_a,
   output logic               gnt_b,
   input  logic               we_a,
   input  logic               we_b,
   input  mem_pkg::mem_addr_t addr_a,
   input  mem_pkg::mem_addr_t addr_b,
   input  umi_pkg::umi_data_t wdata_a,
   input  umi_pkg::umi_data_t wdata_b,
   output logic               sram_en,
   output logic               sram_we,
   output mem_pkg::mem_addr_t sram_addr,
   output umi_pkg::umi_data_t sram_wdata
);

   import mem_pkg::*;

   logic                 prio_q;   // 0 favours a, 1 favours b
   logic [mem_ports-1:0] req_vec;  // {b, a}
   logic [mem_ports-1:0] gnt_vec;

   assign req_vec = {req_b, req_a};

   // winner takes it when alone or when it holds priority
   assign gnt_vec[0] = req_vec[0] & (~req_vec[1] | ~prio_q);
   assign gnt_vec[1] = req_vec[1] & (~req_vec[0] |  prio_q);

   assign gnt_a = gnt_vec[0];
   assign gnt_b = gnt_vec[1];

   // point away from last winner
   always_ff @(posedge clk) begin
      if (!rst_n)        prio_q <= 1'b0;
      else if (|gnt_vec) prio_q <= gnt_vec[0];
   end

   // mux winner onto SRAM, b only when granted
   assign sram_en    = |gnt_vec;
   assign sram_we    = gnt_vec[1] ? we_b : (gnt_vec[0] & we_a);
   assign sram_addr  = gnt_vec[1] ? addr_b : addr_a;
   assign sram_wdata = gnt_vec[1] ? wdata_b : wdata_a;

endmodule

`default_nettype wire

// File: rtl/sram_1p.sv
/* single-port synchronous SRAM, registered read data */
`timescale 1ns/1ns
`default_nettype none

module sram_1p (
   input  logic               clk,
   input  logic               en,
   input  logic               we,
   input  mem_pkg::mem_addr_t addr,
   input  umi_pkg::umi_data_t wdata,
   output umi_pkg::umi_data_t rdata  // valid the cycle after a read
);

   import mem_pkg::*;

   mem_data_t mem_array [0:mem_depth-1];

   always_ff @(posedge clk) begin
      if (en) begin
         if (we) mem_array[addr] <= wdata;
         else    rdata <= mem_array[addr];  // held over writes and idle
      end
   end

endmodule

`default_nettype wire

// File: rtl/umi_mem_top.sv
/* UMI memory top
   two endpoints sharing one SRAM through the round-robin arbiter */
`timescale 1ns/1ns
`default_nettype none

module umi_mem_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               a_req_valid,
   output logic               a_req_ready,
   input  umi_pkg::umi_cmd_t  a_req_cmd,
   input  mem_pkg::mem_addr_t a_req_addr,
   input  umi_pkg::umi_data_t a_req_data,
   output logic               a_resp_valid,
   input  logic               a_resp_ready,
   output umi_pkg::umi_cmd_t  a_resp_cmd,
   output umi_pkg::umi_data_t a_resp_data,
   input  logic               b_req_valid,
   output logic               b_req_ready,
   input  umi_pkg::umi_cmd_t  b_req_cmd,
   input  mem_pkg::mem_addr_t b_req_addr,
   input  umi_pkg::umi_data_t b_req_data,
   output logic               b_resp_valid,
   input  logic               b_resp_ready,
   output umi_pkg::umi_cmd_t  b_resp_cmd,
   output umi_pkg::umi_data_t b_resp_data
);

   import umi_pkg::*;
   import mem_pkg::*;

   logic      req_a, req_b, gnt_a, gnt_b, we_a, we_b;
   mem_addr_t addr_a, addr_b, sram_addr;
   umi_data_t wdata_a, wdata_b, sram_wdata;
   umi_data_t sram_rdata;  // shared by both endpoints
   logic      sram_en, sram_we;

   umi_endpoint u_ep_a (
      .clk (clk), .rst_n (rst_n),
      .req_valid (a_req_valid), .req_ready (a_req_ready),
      .req_cmd (a_req_cmd), .req_addr (a_req_addr), .req_data (a_req_data),
      .resp_valid (a_resp_valid), .resp_ready (a_resp_ready),
      .resp_cmd (a_resp_cmd), .resp_data (a_resp_data),
      .mem_req (req_a), .mem_gnt (gnt_a), .mem_we (we_a),
      .mem_addr (addr_a), .mem_wdata (wdata_a), .mem_rdata (sram_rdata)
   );

   umi_endpoint u_ep_b (
      .clk (clk), .rst_n (rst_n),
      .req_valid (b_req_valid), .req_ready (b_req_ready),
      .req_cmd (b_req_cmd), .req_addr (b_req_addr), .req_data (b_req_data),
      .resp_valid (b_resp_valid), .resp_ready (b_resp_ready),
      .resp_cmd (b_resp_cmd), .resp_data (b_resp_data),
      .mem_req (req_b), .mem_gnt (gnt_b), .mem_we (we_b),
      .mem_addr (addr_b), .mem_wdata (wdata_b), .mem_rdata (sram_rdata)
   );

   mem_arbiter u_arb (
      .clk (clk), .rst_n (rst_n),
      .req_a (req_a), .req_b (req_b), .gnt_a (gnt_a), .gnt_b (gnt_b),
      .we_a (we_a), .we_b (we_b), .addr_a (addr_a), .addr_b (addr_b),
      .wdata_a (wdata_a), .wdata_b (wdata_b),
      .sram_en (sram_en), .sram_we (sram_we),
      .sram_addr (sram_addr), .sram_wdata (sram_wdata)
   );

   sram_1p u_sram (
      .clk (clk), .en (sram_en), .we (sram_we),
      .addr (sram_addr), .wdata (sram_wdata), .rdata (sram_rdata)
   );

endmodule

`default_nettype wire

// File: tests/umi_mem_assert.sv
/* arbiter checks bound into mem_arbiter
   one grant at a time, grant only to a requester, bounded wait */
`timescale 1ns/1ns
`default_nettype none

module umi_mem_assert (
   input logic clk,
   input logic rst_n,
   input logic req_a,
   input logic req_b,
   input logic gnt_a,
   input logic gnt_b
);

   // single SRAM port
   one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(gnt_a && gnt_b))
      else $error("both memory grants high");
   gnt_a_req: assert property (@(posedge clk) disable iff (!rst_n) gnt_a |-> req_a)
      else $error("port a granted without a request");
   gnt_b_req: assert property (@(posedge clk) disable iff (!rst_n) gnt_b |-> req_b)
      else $error("port b granted without a request");
   // loser keeps requesting, priority has flipped to it
   wait_a: assert property (@(posedge clk) disable iff (!rst_n) (req_a && !gnt_a) |=> gnt_a)
      else $error("port a request not granted within two cycles");
   wait_b: assert property (@(posedge clk) disable iff (!rst_n) (req_b && !gnt_b) |=> gnt_b)
      else $error("port b request not granted within two cycles");

endmodule

bind mem_arbiter umi_mem_assert u_arb_assert (
   .clk (clk), .rst_n (rst_n),
   .req_a (req_a), .req_b (req_b), .gnt_a (gnt_a), .gnt_b (gnt_b)
);

`default_nettype wire

// File: tests/tb_umi_mem.sv
/* UMI memory testbench
   table-driven requests on both ports with random gaps and response back-pressure */
`timescale 1ns/1ns
`default_nettype none

module tb_umi_mem;

   import umi_pkg::*;
   import mem_pkg::*;

   localparam int clk_period   = 100;  // ns
   localparam int reset_cycles = 10;
   localparam int row_cycles   = 20;   // watchdog budget per row

   // one transaction, expected values worked out by hand
   typedef struct {
      int        port;      // 0 = a, 1 = b
      umi_cmd_t  cmd;
      mem_addr_t addr;
      umi_data_t wdata;
      umi_cmd_t  exp_cmd;
      umi_data_t exp_data;
      bit        no_resp;   // posted write
   } row_t;

   logic      clk;
   logic      rst_n;
   logic      req_valid [2];
   logic      req_ready [2];
   umi_cmd_t  req_cmd [2];
   mem_addr_t req_addr [2];
   umi_data_t req_data [2];
   logic      resp_valid [2];
   logic      resp_ready [2];
   umi_cmd_t  resp_cmd [2];
   umi_data_t resp_data [2];
   string     pfx [2] = '{"a_", "b_"};  // signal prefix in error lines
   row_t      rows [$];

   umi_mem_top DUT (
      .clk (clk), .rst_n (rst_n),
      .a_req_valid (req_valid[0]), .a_req_ready (req_ready[0]), .a_req_cmd (req_cmd[0]),
      .a_req_addr (req_addr[0]), .a_req_data (req_data[0]),
      .a_resp_valid (resp_valid[0]), .a_resp_ready (resp_ready[0]),
      .a_resp_cmd (resp_cmd[0]), .a_resp_data (resp_data[0]),
      .b_req_valid (req_valid[1]), .b_req_ready (req_ready[1]), .b_req_cmd (req_cmd[1]),
      .b_req_addr (req_addr[1]), .b_req_data (req_data[1]),
      .b_resp_valid (resp_valid[1]), .b_resp_ready (resp_ready[1]),
      .b_resp_cmd (resp_cmd[1]), .b_resp_data (resp_data[1])
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic void add_row(input int port, input umi_cmd_t cmd, input mem_addr_t addr,
                                   input umi_data_t wdata, input umi_cmd_t exp_cmd,
                                   input umi_data_t exp_data, input bit no_resp);
      rows.push_back('{port, cmd, addr, wdata, exp_cmd, exp_data, no_resp});
   endfunction

   function automatic void build_table();
      // port a, write ack then read back
      add_row(0, umi_req_write_ack, 8'h10, 32'hA5A5_0001, umi_resp_write, 32'h0, 1'b0);
      add_row(0, umi_req_read, 8'h10, 32'h0, umi_resp_read, 32'hA5A5_0001, 1'b0);
      add_row(0, umi_req_posted, 8'h11, 32'h1234_5678, umi_invalid, 32'h0, 1'b1);
      add_row(0, umi_req_read, 8'h11, 32'h0, umi_resp_read, 32'h1234_5678, 1'b0);
      // invalid, response class, unknown class, atomic opcode 9
      add_row(0, 8'h00, 8'h10, 32'hFFFF_FFFF, umi_resp_err, 32'h0, 1'b0);
      add_row(0, 8'h03, 8'h10, 32'hFFFF_FFFF, umi_resp_err, 32'h0, 1'b0);
      add_row(0, 8'h0A, 8'h10, 32'hFFFF_FFFF, umi_resp_err, 32'h0, 1'b0);
      add_row(0, 8'h98, 8'h10, 32'hFFFF_FFFF, umi_resp_err, 32'h0, 1'b0);
      add_row(0, umi_req_read, 8'h10, 32'h0, umi_resp_read, 32'hA5A5_0001, 1'b0);
      // read and write-back are separate grants, each port adds into its own word
      add_row(0, umi_req_write_ack, 8'h30, 32'h0000_0100, umi_resp_write, 32'h0, 1'b0);
      add_row(0, umi_req_atomic_add, 8'h30, 32'h0000_0011, umi_resp_read, 32'h0000_0100, 1'b0);
      add_row(0, umi_req_atomic_add, 8'h30, 32'h0000_0022, umi_resp_read, 32'h0000_0111, 1'b0);
      add_row(0, umi_req_read, 8'h30, 32'h0, umi_resp_read, 32'h0000_0133, 1'b0);
      // port b, atomic chain on one word
      // each old word returned is the result of the row before
      add_row(1, umi_req_write_ack, 8'h20, 32'h8000_0010, umi_resp_write, 32'h0, 1'b0);
      add_row(1, umi_req_atomic_max, 8'h20, 32'h0000_0020, umi_resp_read, 32'h8000_0010, 1'b0);
      add_row(1, umi_req_atomic_min, 8'h20, 32'h8000_0030, umi_resp_read, 32'h0000_0020, 1'b0);
      add_row(1, umi_req_atomic_maxu, 8'h20, 32'h0000_0040, umi_resp_read, 32'h8000_0030, 1'b0);
      add_row(1, umi_req_atomic_minu, 8'h20, 32'h0000_0050, umi_resp_read, 32'h8000_0030, 1'b0);
      add_row(1, umi_req_atomic_add, 8'h20, 32'h0000_0005, umi_resp_read, 32'h0000_0050, 1'b0);
      add_row(1, umi_req_atomic_and, 8'h20, 32'h0000_00F0, umi_resp_read, 32'h0000_0055, 1'b0);
      add_row(1, umi_req_atomic_or, 8'h20, 32'h0000_0F0F, umi_resp_read, 32'h0000_0050, 1'b0);
      add_row(1, umi_req_atomic_xor, 8'h20, 32'h0000_00FF, umi_resp_read, 32'h0000_0F5F, 1'b0);
      add_row(1, umi_req_atomic_swap, 8'h20, 32'hCAFE_0001, umi_resp_read, 32'h0000_0FA0, 1'b0);
      add_row(1, umi_req_read, 8'h20, 32'h0, umi_resp_read, 32'hCAFE_0001, 1'b0);
      // adds alongside port a
      add_row(1, umi_req_write_ack, 8'h31, 32'h0000_0200, umi_resp_write, 32'h0, 1'b0);
      add_row(1, umi_req_atomic_add, 8'h31, 32'h0000_0003, umi_resp_read, 32'h0000_0200, 1'b0);
      add_row(1, umi_req_atomic_add, 8'h31, 32'h0000_0004, umi_resp_read, 32'h0000_0203, 1'b0);
      add_row(1, umi_req_read, 8'h31, 32'h0, umi_resp_read, 32'h0000_0207, 1'b0);
   endfunction

   task automatic check_eq(input string sig, input umi_data_t got, input umi_data_t exp);
      assert (got === exp) else begin
         $display("ERR %s got 0x%0h expected 0x%0h", sig, got, exp);
         $display("Test failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // one request, then its response under random back-pressure
   task automatic issue_row(input row_t r);
      int        p;
      umi_cmd_t  held_cmd;
      umi_data_t held_data;
      p = r.port;
      repeat ($urandom_range(0, 3)) @(negedge clk);  // idle gap
      req_valid[p] = 1'b1;
      req_cmd[p]   = r.cmd;
      req_addr[p]  = r.addr;
      req_data[p]  = r.wdata;
      while (!req_ready[p]) @(negedge clk);
      @(negedge clk);  // taken on the rising edge in between
      req_valid[p] = 1'b0;
      if (r.no_resp) begin
         // posted write retires silently
         while (!req_ready[p]) begin
            check_eq({pfx[p], "resp_valid"}, 32'(resp_valid[p]), 32'h0);
            @(negedge clk);
         end
      end else begin
         while (!resp_valid[p]) @(negedge clk);
         held_cmd  = resp_cmd[p];
         held_data = resp_data[p];
         repeat ($urandom_range(0, 3)) begin
            @(negedge clk);
            check_eq({pfx[p], "resp_valid"}, 32'(resp_valid[p]), 32'h1);
            check_eq({pfx[p], "resp_cmd"}, 32'(resp_cmd[p]), 32'(held_cmd));
            check_eq({pfx[p], "resp_data"}, resp_data[p], held_data);
         end
         resp_ready[p] = 1'b1;
         @(negedge clk);
         resp_ready[p] = 1'b0;
         check_eq({pfx[p], "resp_valid"}, 32'(resp_valid[p]), 32'h0);  // sent once
         check_eq({pfx[p], "resp_cmd"}, 32'(held_cmd), 32'(r.exp_cmd));
         check_eq({pfx[p], "resp_data"}, held_data, r.exp_data);
      end
   endtask

   task automatic run_port(input int p);
      foreach (rows[i]) begin
         if (rows[i].port == p) issue_row(rows[i]);
      end
   endtask

   initial begin
      int limit;
      void'($urandom(29435));
      rst_n = 1'b0;
      for (int p = 0; p < 2; p++) begin
         req_valid[p]  = 1'b0;
         req_cmd[p]    = umi_invalid;
         req_addr[p]   = '0;
         req_data[p]   = '0;
         resp_ready[p] = 1'b0;
      end
      build_table();
      limit = (reset_cycles + rows.size() * row_cycles) * clk_period;
      fork
         begin
            #(limit);
            $display("watchdog expired before all responses arrived");
            $display("Test failed");
            $fatal(1, "watchdog");
         end
      join_none
      repeat (reset_cycles) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int p = 0; p < 2; p++) begin
         check_eq({pfx[p], "req_ready"}, 32'(req_ready[p]), 32'h1);
         check_eq({pfx[p], "resp_valid"}, 32'(resp_valid[p]), 32'h0);
      end
      // both ports at once, contention at the arbiter
      fork
         run_port(0);
         run_port(1);
      join
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
rtl/umi_pkg.sv
rtl/mem_pkg.sv
rtl/umi_decode.sv
rtl/umi_atomic_alu.sv
rtl/umi_endpoint.sv
rtl/mem_arbiter.sv
rtl/sram_1p.sv
rtl/umi_mem_top.sv
tests/umi_mem_assert.sv
tests/tb_umi_mem.sv

// File: run.sh
#!/bin/sh
# build and run the UMI memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
   -f list.f --top-module tb_umi_mem -o sim_umi_mem
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/sim_umi_mem 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Test completed successfully"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
